// File: include/lsu_defines.svh
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// ------------------------------------------------------------------------
// Datapath widths
// ------------------------------------------------------------------------
`define LSU_XLEN      32
`define LSU_ADDR_W    10   // Byte address into the data array
`define LSU_TAG_W     4
`define LSU_REG_W     5

// 256 words of 32 bits covers the whole 10-bit byte address space
`define LSU_DC_WORDS  256

// ------------------------------------------------------------------------
// RV32 major opcodes, inst[6:0]
// ------------------------------------------------------------------------
`define LSU_OPC_LOAD  7'b0000011
`define LSU_OPC_STORE 7'b0100011

`endif

// File: src/lsu_pkg.sv
package lsu_pkg;

  // ------------------------------------------------------------------------
  // Decoded operation
  // ------------------------------------------------------------------------
  typedef enum logic [1:0] {
    OP_NONE  = 2'd0,
    OP_LOAD  = 2'd1,
    OP_STORE = 2'd2
  } lsu_op_e;

  // Encoding follows funct3[1:0] of the RV32 load/store group
  typedef enum logic [1:0] {
    SIZE_B = 2'd0,
    SIZE_H = 2'd1,
    SIZE_W = 2'd2
  } lsu_size_e;

  typedef enum logic {
    SIGN_S = 1'b0,
    SIGN_U = 1'b1   // LBU, LHU
  } lsu_sign_e;

  // ------------------------------------------------------------------------
  // Completion status
  // ------------------------------------------------------------------------
  typedef enum logic [1:0] {
    EXC_NONE        = 2'd0,
    EXC_LD_MISALIGN = 2'd1,
    EXC_ST_MISALIGN = 2'd2,
    EXC_ILLEGAL     = 2'd3
  } lsu_except_e;

endpackage

// File: src/lsu_ctrl.sv
`timescale 1ns/10ps
`include "lsu_defines.svh"

module lsu_ctrl
  import lsu_pkg::*;
(
  input  logic                  i_clk,
  input  logic                  i_reset_n,
  input  logic                  i_issue_valid,
  input  logic [31:0]           i_issue_inst,
  input  logic [`LSU_TAG_W-1:0] i_issue_tag,
  input  logic [`LSU_XLEN-1:0]  i_issue_rs1,
  input  logic [`LSU_XLEN-1:0]  i_issue_rs2,
  input  logic                  i_replay_valid,
  input  logic [31:0]           i_replay_inst,
  input  logic [`LSU_TAG_W-1:0] i_replay_tag,
  input  logic [`LSU_XLEN-1:0]  i_replay_rs1,
  input  logic [`LSU_XLEN-1:0]  i_replay_rs2,
  input  logic                  i_ex1_misalign,
  output logic                  o_conflict_valid,
  output logic [`LSU_TAG_W-1:0] o_conflict_tag,
  output logic [`LSU_XLEN-1:0]  o_ex1_rs1,
  output logic [`LSU_XLEN-1:0]  o_ex1_imm,
  output logic [`LSU_XLEN-1:0]  o_ex1_rs2,
  output lsu_size_e             o_ex1_size,
  output logic                  o_ex1_is_store,
  output logic                  o_ex1_rd_en,
  output logic                  o_ex2_wr_en,
  output lsu_size_e             o_ex2_size,
  output lsu_sign_e             o_ex2_sign,
  output logic                  o_done_valid,
  output logic [`LSU_TAG_W-1:0] o_done_tag,
  output lsu_except_e           o_done_except,
  output logic                  o_wr_valid,
  output logic [`LSU_REG_W-1:0] o_wr_rd
);

  logic                  r_ex0_valid;
  logic [31:0]           r_ex0_inst;
  logic [`LSU_TAG_W-1:0] r_ex0_tag;
  logic [`LSU_XLEN-1:0]  r_ex0_rs1, r_ex0_rs2;

  logic                  w_ex0_valid;
  logic [31:0]           w_ex0_inst;
  logic [`LSU_TAG_W-1:0] w_ex0_tag;
  logic [`LSU_XLEN-1:0]  w_ex0_rs1, w_ex0_rs2, w_ex0_imm;
  logic [2:0]            w_ex0_funct3;
  lsu_op_e               w_ex0_op;
  lsu_except_e           w_ex0_except;

  logic                  r_ex1_valid, r_ex2_valid, r_ex3_valid;
  logic [`LSU_TAG_W-1:0] r_ex1_tag, r_ex2_tag, r_ex3_tag;
  logic [`LSU_REG_W-1:0] r_ex1_rd, r_ex2_rd, r_ex3_rd;
  lsu_op_e               r_ex1_op, r_ex2_op, r_ex3_op;
  lsu_size_e             r_ex1_size, r_ex2_size;
  lsu_sign_e             r_ex1_sign, r_ex2_sign;
  lsu_except_e           r_ex1_except, r_ex2_except, r_ex3_except;
  logic [`LSU_XLEN-1:0]  r_ex1_rs1, r_ex1_rs2, r_ex1_imm;
  lsu_except_e           w_ex1_except;

  // ------------------------------------------------------------------------
  // EX0: held issue vs. replay
  // ------------------------------------------------------------------------
  assign w_ex0_valid  = i_replay_valid | r_ex0_valid;
  assign w_ex0_inst   = i_replay_valid ? i_replay_inst : r_ex0_inst;
  assign w_ex0_tag    = i_replay_valid ? i_replay_tag  : r_ex0_tag;
  assign w_ex0_rs1    = i_replay_valid ? i_replay_rs1  : r_ex0_rs1;
  assign w_ex0_rs2    = i_replay_valid ? i_replay_rs2  : r_ex0_rs2;
  assign w_ex0_funct3 = w_ex0_inst[14:12];

  assign o_conflict_valid = i_replay_valid & r_ex0_valid; // Held issue is dropped
  assign o_conflict_tag   = r_ex0_tag;

  always_comb begin
    w_ex0_op     = OP_NONE;
    w_ex0_except = EXC_ILLEGAL;
    w_ex0_imm    = {{(`LSU_XLEN-12){w_ex0_inst[31]}}, w_ex0_inst[31:20]};
    if (w_ex0_inst[6:0] == `LSU_OPC_LOAD) begin
      // LB LH LW LBU LHU
      if (w_ex0_funct3[1:0] != 2'b11 && !(w_ex0_funct3[2] && w_ex0_funct3[1])) begin
        w_ex0_op     = OP_LOAD;
        w_ex0_except = EXC_NONE;
      end
    end else if (w_ex0_inst[6:0] == `LSU_OPC_STORE) begin
      w_ex0_imm = {{(`LSU_XLEN-12){w_ex0_inst[31]}}, w_ex0_inst[31:25], w_ex0_inst[11:7]};
      if (!w_ex0_funct3[2] && w_ex0_funct3[1:0] != 2'b11) begin // SB SH SW
        w_ex0_op     = OP_STORE;
        w_ex0_except = EXC_NONE;
      end
    end
  end

  // Misalignment is only raised on otherwise legal accesses
  always_comb begin
    w_ex1_except = r_ex1_except;
    if (i_ex1_misalign && r_ex1_except == EXC_NONE) begin
      w_ex1_except = (r_ex1_op == OP_STORE) ? EXC_ST_MISALIGN : EXC_LD_MISALIGN;
    end
  end

  // ------------------------------------------------------------------------
  // Stage registers
  // ------------------------------------------------------------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex0_valid <= 1'b0;
      r_ex1_valid <= 1'b0;
      r_ex2_valid <= 1'b0;
      r_ex3_valid <= 1'b0;
    end else begin
      r_ex0_valid <= i_issue_valid;
      r_ex1_valid <= w_ex0_valid;
      r_ex2_valid <= r_ex1_valid;
      r_ex3_valid <= r_ex2_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    r_ex0_inst   <= i_issue_inst;
    r_ex0_tag    <= i_issue_tag;
    r_ex0_rs1    <= i_issue_rs1;
    r_ex0_rs2    <= i_issue_rs2;

    r_ex1_tag    <= w_ex0_tag;
    r_ex1_rd     <= w_ex0_inst[11:7];
    r_ex1_op     <= w_ex0_op;
    r_ex1_size   <= lsu_size_e'(w_ex0_funct3[1:0]);
    r_ex1_sign   <= w_ex0_funct3[2] ? SIGN_U : SIGN_S;
    r_ex1_except <= w_ex0_except;
    r_ex1_rs1    <= w_ex0_rs1;
    r_ex1_rs2    <= w_ex0_rs2;
    r_ex1_imm    <= w_ex0_imm;

    r_ex2_tag    <= r_ex1_tag;
    r_ex2_rd     <= r_ex1_rd;
    r_ex2_op     <= r_ex1_op;
    r_ex2_size   <= r_ex1_size;
    r_ex2_sign   <= r_ex1_sign;
    r_ex2_except <= w_ex1_except;

    r_ex3_tag    <= r_ex2_tag;
    r_ex3_rd     <= r_ex2_rd;
    r_ex3_op     <= r_ex2_op;
    r_ex3_except <= r_ex2_except;
  end

  assign o_ex1_rs1      = r_ex1_rs1;
  assign o_ex1_imm      = r_ex1_imm;
  assign o_ex1_rs2      = r_ex1_rs2;
  assign o_ex1_size     = r_ex1_size;
  assign o_ex1_is_store = r_ex1_valid & (r_ex1_op == OP_STORE);
  assign o_ex1_rd_en    = r_ex1_valid & (r_ex1_op == OP_LOAD);

  assign o_ex2_wr_en = r_ex2_valid & (r_ex2_op == OP_STORE) & (r_ex2_except == EXC_NONE);
  assign o_ex2_size  = r_ex2_size;
  assign o_ex2_sign  = r_ex2_sign;

  assign o_done_valid  = r_ex3_valid;
  assign o_done_tag    = r_ex3_tag;
  assign o_done_except = r_ex3_except;
  assign o_wr_valid    = r_ex3_valid & (r_ex3_op == OP_LOAD) &
                         (r_ex3_except == EXC_NONE) & (r_ex3_rd != '0);
  assign o_wr_rd       = r_ex3_rd;

endmodule

// File: src/lsu_agu.sv
`timescale 1ns/10ps
`include "lsu_defines.svh"

module lsu_agu
  import lsu_pkg::*;
(
  input  logic                     i_clk,
  input  logic                     i_reset_n,
  input  logic [`LSU_XLEN-1:0]     i_ex1_rs1,
  input  logic [`LSU_XLEN-1:0]     i_ex1_imm,
  input  logic [`LSU_XLEN-1:0]     i_ex1_rs2,
  input  lsu_size_e                i_ex1_size,
  output logic [`LSU_ADDR_W-1:0]   o_ex1_addr,
  output logic                     o_ex1_misalign,
  output logic [`LSU_ADDR_W-1:0]   o_ex2_addr,
  output logic [`LSU_XLEN-1:0]     o_ex2_st_data,
  output logic [`LSU_XLEN/8-1:0]   o_ex2_st_mask
);

  logic [`LSU_XLEN/8-1:0] w_ex1_mask;

  // Upper sum bits fall outside the array, so only the low bits are added
  assign o_ex1_addr = i_ex1_rs1[`LSU_ADDR_W-1:0] + i_ex1_imm[`LSU_ADDR_W-1:0];

  assign o_ex1_misalign = (i_ex1_size == SIZE_H) ? o_ex1_addr[0] :
                          (i_ex1_size == SIZE_W) ? (o_ex1_addr[1:0] != 2'b00) :
                          1'b0;

  always_comb begin
    case (i_ex1_size)
      SIZE_H:  w_ex1_mask = 4'b0011;
      SIZE_W:  w_ex1_mask = 4'b1111;
      default: w_ex1_mask = 4'b0001;
    endcase
  end

  // ------------------------------------------------------------------------
  // EX2 registers, store operand moved to its byte lane
  // ------------------------------------------------------------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_ex2_addr    <= '0;
      o_ex2_st_data <= '0;
      o_ex2_st_mask <= '0;
    end else begin
      o_ex2_addr    <= o_ex1_addr;
      o_ex2_st_data <= i_ex1_rs2 << {o_ex1_addr[1:0], 3'b000};
      o_ex2_st_mask <= w_ex1_mask << o_ex1_addr[1:0];
    end
  end

endmodule

// File: src/lsu_dcache.sv
`timescale 1ns/10ps
`include "lsu_defines.svh"

module lsu_dcache (
  input  logic                   i_clk,
  input  logic                   i_reset_n,
  input  logic                   i_rd_en,
  input  logic [`LSU_ADDR_W-1:0] i_rd_addr,
  input  logic                   i_wr_en,
  input  logic [`LSU_ADDR_W-1:0] i_wr_addr,
  input  logic [`LSU_XLEN-1:0]   i_wr_data,
  input  logic [`LSU_XLEN/8-1:0] i_wr_mask,
  output logic [`LSU_XLEN-1:0]   o_rd_data,
  output logic                   o_fwd_hit,
  output logic [`LSU_XLEN-1:0]   o_fwd_data,
  output logic [`LSU_XLEN/8-1:0] o_fwd_mask
);

  logic [`LSU_XLEN-1:0]   r_mem [`LSU_DC_WORDS];
  logic [`LSU_ADDR_W-1:2] r_rd_idx;    // Word now being returned

  logic                   r_lw_valid;
  logic [`LSU_ADDR_W-1:2] r_lw_idx;
  logic [`LSU_XLEN-1:0]   r_lw_data;
  logic [`LSU_XLEN/8-1:0] r_lw_mask;

  // ------------------------------------------------------------------------
  // Word array with byte-lane writes
  // ------------------------------------------------------------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int w = 0; w < `LSU_DC_WORDS; w++) begin
        r_mem[w] <= '0;
      end
    end else if (i_wr_en) begin
      for (int b = 0; b < `LSU_XLEN/8; b++) begin
        if (i_wr_mask[b]) begin
          r_mem[i_wr_addr[`LSU_ADDR_W-1:2]][b*8 +: 8] <= i_wr_data[b*8 +: 8];
        end
      end
    end
  end

  // Read sees the array before this edge's write
  always_ff @(posedge i_clk) begin
    if (i_rd_en) begin
      o_rd_data <= r_mem[i_rd_addr[`LSU_ADDR_W-1:2]];
      r_rd_idx  <= i_rd_addr[`LSU_ADDR_W-1:2];
    end
  end

  // ------------------------------------------------------------------------
  // Last write, covers a load one cycle behind a store
  // ------------------------------------------------------------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_lw_valid <= 1'b0;
    end else begin
      r_lw_valid <= i_wr_en;
    end
  end

  always_ff @(posedge i_clk) begin
    r_lw_idx  <= i_wr_addr[`LSU_ADDR_W-1:2];
    r_lw_data <= i_wr_data;
    r_lw_mask <= i_wr_mask;
  end

  assign o_fwd_hit  = r_lw_valid & (r_lw_idx == r_rd_idx);
  assign o_fwd_data = r_lw_data;
  assign o_fwd_mask = r_lw_mask;

endmodule

// File: src/lsu_load_align.sv
`timescale 1ns/10ps
`include "lsu_defines.svh"

module lsu_load_align
  import lsu_pkg::*;
(
  input  logic                   i_clk,
  input  logic                   i_reset_n,
  input  logic [1:0]             i_ex2_addr,   // Byte offset in word
  input  lsu_size_e              i_ex2_size,
  input  lsu_sign_e              i_ex2_sign,
  input  logic [`LSU_XLEN-1:0]   i_rd_data,
  input  logic                   i_fwd_hit,
  input  logic [`LSU_XLEN-1:0]   i_fwd_data,
  input  logic [`LSU_XLEN/8-1:0] i_fwd_mask,
  output logic [`LSU_XLEN-1:0]   o_ex3_data
);

  logic [`LSU_XLEN-1:0] w_ex2_merged;
  logic [`LSU_XLEN-1:0] w_ex2_shifted;
  logic [`LSU_XLEN-1:0] w_ex2_data;
  logic                 w_ex2_msb;

  // ------------------------------------------------------------------------
  // Byte merge with the previous cycle's store
  // ------------------------------------------------------------------------
  always_comb begin
    for (int b = 0; b < `LSU_XLEN/8; b++) begin
      w_ex2_merged[b*8 +: 8] = (i_fwd_hit && i_fwd_mask[b]) ? i_fwd_data[b*8 +: 8] :
                                                              i_rd_data[b*8 +: 8];
    end
  end

  assign w_ex2_shifted = w_ex2_merged >> {i_ex2_addr, 3'b000};

  // ------------------------------------------------------------------------
  // Size select and extension
  // ------------------------------------------------------------------------
  always_comb begin
    case (i_ex2_size)
      SIZE_B:  w_ex2_msb = w_ex2_shifted[7];
      SIZE_H:  w_ex2_msb = w_ex2_shifted[15];
      default: w_ex2_msb = w_ex2_shifted[31];
    endcase
    if (i_ex2_sign == SIGN_U) begin
      w_ex2_msb = 1'b0;       // LBU, LHU
    end
  end

  always_comb begin
    case (i_ex2_size)
      SIZE_B:  w_ex2_data = {{(`LSU_XLEN-8){w_ex2_msb}}, w_ex2_shifted[7:0]};
      SIZE_H:  w_ex2_data = {{(`LSU_XLEN-16){w_ex2_msb}}, w_ex2_shifted[15:0]};
      default: w_ex2_data = w_ex2_shifted;
    endcase
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_ex3_data <= '0;
    end else begin
      o_ex3_data <= w_ex2_data;
    end
  end

endmodule

// File: src/lsu_pipe.sv
`timescale 1ns/10ps
`include "lsu_defines.svh"

module lsu_pipe
  import lsu_pkg::*;
(
  input  logic                  i_clk,
  input  logic                  i_reset_n,
  input  logic                  i_issue_valid,
  input  logic [31:0]           i_issue_inst,
  input  logic [`LSU_TAG_W-1:0] i_issue_tag,
  input  logic [`LSU_XLEN-1:0]  i_issue_rs1,
  input  logic [`LSU_XLEN-1:0]  i_issue_rs2,
  input  logic                  i_replay_valid,
  input  logic [31:0]           i_replay_inst,
  input  logic [`LSU_TAG_W-1:0] i_replay_tag,
  input  logic [`LSU_XLEN-1:0]  i_replay_rs1,
  input  logic [`LSU_XLEN-1:0]  i_replay_rs2,
  output logic                  o_conflict_valid,
  output logic [`LSU_TAG_W-1:0] o_conflict_tag,
  output logic                  o_done_valid,
  output logic [`LSU_TAG_W-1:0] o_done_tag,
  output lsu_except_e           o_done_except,
  output logic                  o_wr_valid,
  output logic [`LSU_REG_W-1:0] o_wr_rd,
  output logic [`LSU_XLEN-1:0]  o_wr_data
);

  // EX1
  logic [`LSU_XLEN-1:0]   ex1_rs1, ex1_imm, ex1_rs2;
  lsu_size_e              ex1_size;
  logic                   ex1_is_store, ex1_rd_en, ex1_misalign;
  logic [`LSU_ADDR_W-1:0] ex1_addr;

  // EX2
  logic                   ex2_wr_en;
  lsu_size_e              ex2_size;
  lsu_sign_e              ex2_sign;
  logic [`LSU_ADDR_W-1:0] ex2_addr;
  logic [`LSU_XLEN-1:0]   ex2_st_data, ex2_rd_data, ex2_fwd_data;
  logic [`LSU_XLEN/8-1:0] ex2_st_mask, ex2_fwd_mask;
  logic                   ex2_fwd_hit;

  lsu_ctrl u_ctrl (
    .i_clk            (i_clk),
    .i_reset_n        (i_reset_n),
    .i_issue_valid    (i_issue_valid),
    .i_issue_inst     (i_issue_inst),
    .i_issue_tag      (i_issue_tag),
    .i_issue_rs1      (i_issue_rs1),
    .i_issue_rs2      (i_issue_rs2),
    .i_replay_valid   (i_replay_valid),
    .i_replay_inst    (i_replay_inst),
    .i_replay_tag     (i_replay_tag),
    .i_replay_rs1     (i_replay_rs1),
    .i_replay_rs2     (i_replay_rs2),
    .i_ex1_misalign   (ex1_misalign),
    .o_conflict_valid (o_conflict_valid),
    .o_conflict_tag   (o_conflict_tag),
    .o_ex1_rs1        (ex1_rs1),
    .o_ex1_imm        (ex1_imm),
    .o_ex1_rs2        (ex1_rs2),
    .o_ex1_size       (ex1_size),
    .o_ex1_is_store   (ex1_is_store),
    .o_ex1_rd_en      (ex1_rd_en),
    .o_ex2_wr_en      (ex2_wr_en),
    .o_ex2_size       (ex2_size),
    .o_ex2_sign       (ex2_sign),
    .o_done_valid     (o_done_valid),
    .o_done_tag       (o_done_tag),
    .o_done_except    (o_done_except),
    .o_wr_valid       (o_wr_valid),
    .o_wr_rd          (o_wr_rd)
  );

  lsu_agu u_agu (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_ex1_rs1      (ex1_rs1),
    .i_ex1_imm      (ex1_imm),
    .i_ex1_rs2      (ex1_rs2),
    .i_ex1_size     (ex1_size),
    .o_ex1_addr     (ex1_addr),
    .o_ex1_misalign (ex1_misalign),
    .o_ex2_addr     (ex2_addr),
    .o_ex2_st_data  (ex2_st_data),
    .o_ex2_st_mask  (ex2_st_mask)
  );

  // Array port is shared: loads read in EX1, stores write in EX2
  lsu_dcache u_dcache (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_rd_en    (ex1_rd_en & ~ex1_is_store),
    .i_rd_addr  (ex1_addr),
    .i_wr_en    (ex2_wr_en),
    .i_wr_addr  (ex2_addr),
    .i_wr_data  (ex2_st_data),
    .i_wr_mask  (ex2_st_mask),
    .o_rd_data  (ex2_rd_data),
    .o_fwd_hit  (ex2_fwd_hit),
    .o_fwd_data (ex2_fwd_data),
    .o_fwd_mask (ex2_fwd_mask)
  );

  lsu_load_align u_load_align (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_ex2_addr (ex2_addr[1:0]),
    .i_ex2_size (ex2_size),
    .i_ex2_sign (ex2_sign),
    .i_rd_data  (ex2_rd_data),
    .i_fwd_hit  (ex2_fwd_hit),
    .i_fwd_data (ex2_fwd_data),
    .i_fwd_mask (ex2_fwd_mask),
    .o_ex3_data (o_wr_data)
  );

endmodule

// File: dv/tb_lsu_pipe.sv
`timescale 1ns/10ps
`include "lsu_defines.svh"

module tb_lsu_pipe
  import lsu_pkg::*;
();

  localparam int CLK_PERIOD     = 20;
  localparam int RESET_CYCLES   = 10;
  localparam int RAND_ROUNDS    = 3;
  localparam int RAND_BATCH     = 8;
  localparam int FWD_TRIPLES    = 6;
  localparam int N_ISSUES       = RAND_ROUNDS * RAND_BATCH * 2 + FWD_TRIPLES * 3 + 14;
  localparam int TIMEOUT_CYCLES = N_ISSUES + 20;
  localparam int MODE_ISSUE     = 0;
  localparam int MODE_REPLAY    = 1;
  localparam int MODE_DROP      = 2;   // Issue that a replay pushes out

  typedef struct packed {
    logic [3:0]  tag;
    logic [1:0]  exc;
    logic        wr;
    logic [4:0]  rd;
    logic [31:0] data;
  } exp_t;

  logic                  i_clk;
  logic                  i_reset_n;
  logic                  i_issue_valid, i_replay_valid;
  logic [31:0]           i_issue_inst, i_replay_inst;
  logic [`LSU_TAG_W-1:0] i_issue_tag, i_replay_tag;
  logic [`LSU_XLEN-1:0]  i_issue_rs1, i_issue_rs2, i_replay_rs1, i_replay_rs2;
  logic                  o_conflict_valid, o_done_valid, o_wr_valid;
  logic [`LSU_TAG_W-1:0] o_conflict_tag, o_done_tag;
  lsu_except_e           o_done_except;
  logic [`LSU_REG_W-1:0] o_wr_rd;
  logic [`LSU_XLEN-1:0]  o_wr_data;

  logic [31:0] ref_mem [`LSU_DC_WORDS];   // Mirror of the data array
  exp_t        exp_q [$];
  string       name_q [$];
  logic [3:0]  conflict_q [$];
  logic [31:0] lfsr_q     = 32'd83031;
  logic [3:0]  tag_cnt    = 4'd0;
  int          n_mismatch = 0;
  int          n_proto    = 0;
  int          n_done     = 0;
  int          cycle_cnt  = 0;

  lsu_pipe dut_i (.*);

  initial begin
    i_clk = 1'b0;
    forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
  end

  // ------------------------------------------------------------------------
  // Random source and reference model
  // ------------------------------------------------------------------------
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = 32'd0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      v      = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic logic [9:0] align_addr(input logic [9:0] addr, input logic [1:0] size);
    case (size)
      2'd1:    return {addr[9:1], 1'b0};
      2'd2:    return {addr[9:2], 2'b00};
      default: return addr;
    endcase
  endfunction

  function automatic logic [31:0] load_ref(input logic [9:0] addr, input logic [2:0] f3);
    logic [31:0] w;
    logic [31:0] s;
    w = ref_mem[addr[9:2]];
    s = w >> (8 * addr[1:0]);
    case (f3)
      3'b000:  return {{24{s[7]}}, s[7:0]};    // LB
      3'b001:  return {{16{s[15]}}, s[15:0]};  // LH
      3'b100:  return {24'd0, s[7:0]};
      3'b101:  return {16'd0, s[15:0]};
      default: return w;
    endcase
  endfunction

  task automatic store_ref(input logic [9:0] addr, input logic [2:0] f3, input logic [31:0] d);
    int nbytes;
    nbytes = (f3 == 3'd0) ? 1 : (f3 == 3'd1) ? 2 : 4;
    for (int b = 0; b < nbytes; b++) begin
      ref_mem[addr[9:2]][(addr[1:0] + b) * 8 +: 8] = d[b*8 +: 8];
    end
  endtask

  // ------------------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------------------
  task automatic drive_slot(input logic iv, input logic rv, input logic [31:0] inst,
                            input logic [3:0] tag, input logic [31:0] rs1,
                            input logic [31:0] rs2);
    @(posedge i_clk);
    #2;
    i_issue_valid  = iv;
    i_issue_inst   = inst;
    i_issue_tag    = tag;
    i_issue_rs1    = rs1;
    i_issue_rs2    = rs2;
    i_replay_valid = rv;
    i_replay_inst  = inst;
    i_replay_tag   = tag;
    i_replay_rs1   = rs1;
    i_replay_rs2   = rs2;
  endtask

  task automatic do_access(input string name, input logic is_store, input logic [2:0] f3,
                           input logic [9:0] addr, input logic [4:0] rd,
                           input logic [31:0] data, input int mode);
    logic [11:0] imm;
    logic [31:0] rs1;
    logic [31:0] inst;
    logic        legal;
    logic        misal;
    exp_t        e;
    imm      = rand_bits(12);
    rs1      = rand_bits(32);
    rs1[9:0] = addr - imm[9:0];   // Upper rs1 bits fall off the address
    if (is_store) begin
      inst = {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], `LSU_OPC_STORE};
    end else begin
      inst = {imm, 5'd1, f3, rd, `LSU_OPC_LOAD};
    end
    legal  = is_store ? (f3 <= 3'd2) : (f3 != 3'd3 && f3 < 3'd6);
    misal  = (f3[1:0] == 2'd1 && addr[0]) || (f3[1:0] == 2'd2 && addr[1:0] != 2'd0);
    e.tag  = tag_cnt;
    e.exc  = !legal ? EXC_ILLEGAL :
             misal ? (is_store ? EXC_ST_MISALIGN : EXC_LD_MISALIGN) : EXC_NONE;
    e.wr   = !is_store && e.exc == EXC_NONE && rd != 5'd0;
    e.rd   = rd;
    e.data = e.wr ? load_ref(addr, f3) : 32'd0;
    if (mode == MODE_DROP) begin
      conflict_q.push_back(tag_cnt);
    end else begin
      exp_q.push_back(e);
      name_q.push_back(name);
      if (is_store && e.exc == EXC_NONE) store_ref(addr, f3, data);
    end
    drive_slot(mode != MODE_REPLAY, mode == MODE_REPLAY, inst, tag_cnt, rs1, data);
    tag_cnt = tag_cnt + 4'd1;
  endtask

  initial begin : stimulus
    logic [9:0]  addrs [RAND_BATCH];
    logic [9:0]  a;
    logic [9:0]  wa;
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic [31:0] d;
    i_reset_n      = 1'b0;
    i_issue_valid  = 1'b1;   // Active valids must not get through reset
    i_issue_inst   = 32'd0;
    i_issue_tag    = 4'd0;
    i_issue_rs1    = 32'd0;
    i_issue_rs2    = 32'd0;
    i_replay_valid = 1'b1;
    i_replay_inst  = 32'd0;
    i_replay_tag   = 4'd0;
    i_replay_rs1   = 32'd0;
    i_replay_rs2   = 32'd0;
    for (int w = 0; w < `LSU_DC_WORDS; w++) ref_mem[w] = 32'd0;
    repeat (RESET_CYCLES) @(posedge i_clk);
    #2;
    if (o_done_valid !== 1'b0 || o_wr_valid !== 1'b0 || o_conflict_valid !== 1'b0) begin
      $display("Outputs were not idle during reset");
      n_proto++;
    end
    i_issue_valid  = 1'b0;
    i_replay_valid = 1'b0;
    i_reset_n      = 1'b1;

    // Stores in a batch, then loads back from the same words
    for (int r = 0; r < RAND_ROUNDS; r++) begin
      for (int i = 0; i < RAND_BATCH; i++) begin
        d        = rand_bits(2);
        f3       = (d[1:0] == 2'd3) ? 3'd2 : {1'b0, d[1:0]};
        d        = rand_bits(10);
        a        = align_addr(d[9:0], f3[1:0]);
        addrs[i] = a;
        d        = rand_bits(32);
        do_access("rand_store", 1'b1, f3, a, 5'd0, d, MODE_ISSUE);
      end
      for (int i = 0; i < RAND_BATCH; i++) begin
        d  = rand_bits(3);
        f3 = (d[2:0] == 3'd3 || d[2:0] > 3'd5) ? 3'd2 : d[2:0];
        d  = rand_bits(5);
        rd = (d[4:0] == 5'd0) ? 5'd1 : d[4:0];
        a  = align_addr(addrs[i], f3[1:0]);
        do_access("rand_load", 1'b0, f3, a, rd, 32'd0, MODE_ISSUE);
      end
    end

    // SW, then SB or SH, then LW one cycle behind the second store
    for (int i = 0; i < FWD_TRIPLES; i++) begin
      d  = rand_bits(8);
      wa = {d[7:0], 2'b00};
      d  = rand_bits(32);
      do_access("fwd_store", 1'b1, 3'd2, wa, 5'd0, d, MODE_ISSUE);
      d  = rand_bits(3);
      f3 = {2'b00, d[2]};
      a  = align_addr({wa[9:2], d[1:0]}, f3[1:0]);
      d  = rand_bits(32);
      do_access("fwd_store", 1'b1, f3, a, 5'd0, d, MODE_ISSUE);
      do_access("fwd_load", 1'b0, 3'd2, wa, 5'd7, 32'd0, MODE_ISSUE);
    end

    do_access("misalign_lh", 1'b0, 3'd1, wa | 10'd1, 5'd3, 32'd0, MODE_ISSUE);
    do_access("misalign_lw", 1'b0, 3'd2, wa | 10'd2, 5'd3, 32'd0, MODE_ISSUE);
    d = rand_bits(32);
    do_access("misalign_sh", 1'b1, 3'd1, wa | 10'd3, 5'd0, d, MODE_ISSUE);
    do_access("misalign_check", 1'b0, 3'd2, wa, 5'd4, 32'd0, MODE_ISSUE);

    d = rand_bits(32);
    do_access("conflict_drop", 1'b1, 3'd2, wa, 5'd0, d, MODE_DROP);
    do_access("conflict_replay", 1'b0, 3'd2, wa, 5'd5, 32'd0, MODE_REPLAY);
    do_access("conflict_drop", 1'b0, 3'd2, wa, 5'd6, 32'd0, MODE_DROP);
    d = rand_bits(32);
    do_access("conflict_replay", 1'b1, 3'd2, wa, 5'd0, d, MODE_REPLAY);

    do_access("rd_zero_load", 1'b0, 3'd2, wa, 5'd0, 32'd0, MODE_ISSUE);
    d = rand_bits(32);
    do_access("store_no_wr", 1'b1, 3'd2, wa, 5'd0, d, MODE_ISSUE);

    do_access("illegal_ld3", 1'b0, 3'd3, wa, 5'd8, 32'd0, MODE_ISSUE);
    do_access("illegal_ld6", 1'b0, 3'd6, wa, 5'd8, 32'd0, MODE_ISSUE);
    do_access("illegal_ld7", 1'b0, 3'd7, wa, 5'd8, 32'd0, MODE_ISSUE);
    d = rand_bits(32);
    do_access("illegal_st3", 1'b1, 3'd3, wa, 5'd0, d, MODE_ISSUE);

    drive_slot(1'b0, 1'b0, 32'd0, 4'd0, 32'd0, 32'd0);
    while (exp_q.size() != 0) @(posedge i_clk);
    repeat (4) @(posedge i_clk);   // Room for stray completions
    if (conflict_q.size() != 0) begin
      $display("%0d expected conflict reports never appeared", conflict_q.size());
      n_proto++;
    end
    $display("Errors: %0d value mismatches, %0d protocol errors, %0d completions checked",
             n_mismatch, n_proto, n_done);
    if (n_mismatch + n_proto == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // ------------------------------------------------------------------------
  // Compare, sampled mid-cycle
  // ------------------------------------------------------------------------
  always @(negedge i_clk) begin : compare_blk
    exp_t       e;
    string      nm;
    logic [3:0] ct;
    if (i_reset_n && o_done_valid) begin
      if (exp_q.size() == 0) begin
        $display("Completion with tag %0d arrived with nothing outstanding", o_done_tag);
        n_proto++;
      end else begin
        e  = exp_q.pop_front();
        nm = name_q.pop_front();
        n_done++;
        if (o_done_tag !== e.tag) begin
          $display("FAIL %s tag: expected %0d, actual %0d", nm, e.tag, o_done_tag);
          n_mismatch++;
        end
        if (o_done_except !== e.exc) begin
          $display("FAIL %s except: expected %0d, actual %0d", nm, e.exc, o_done_except);
          n_mismatch++;
        end
        if (o_wr_valid !== e.wr) begin
          $display("FAIL %s wr_valid: expected %0b, actual %0b", nm, e.wr, o_wr_valid);
          n_mismatch++;
        end
        if (e.wr && o_wr_rd !== e.rd) begin
          $display("FAIL %s wr_rd: expected %0d, actual %0d", nm, e.rd, o_wr_rd);
          n_mismatch++;
        end
        if (e.wr && o_wr_data !== e.data) begin
          $display("FAIL %s wr_data: expected %08h, actual %08h", nm, e.data, o_wr_data);
          n_mismatch++;
        end
      end
    end else if (i_reset_n && o_wr_valid) begin
      $display("Register write to x%0d without a completion", o_wr_rd);
      n_proto++;
    end
    if (i_reset_n && o_conflict_valid) begin
      if (conflict_q.size() == 0) begin
        $display("Conflict reported for tag %0d with no collision driven", o_conflict_tag);
        n_proto++;
      end else begin
        ct = conflict_q.pop_front();
        if (o_conflict_tag !== ct) begin
          $display("FAIL conflict tag: expected %0d, actual %0d", ct, o_conflict_tag);
          n_mismatch++;
        end
      end
    end
  end

  always @(posedge i_clk) begin
    if (i_reset_n) begin
      cycle_cnt++;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
        $display("Timeout after %0d cycles with %0d completions still missing",
                 cycle_cnt, exp_q.size());
        $display("Errors: %0d value mismatches, %0d protocol errors, %0d completions checked",
                 n_mismatch, n_proto + 1, n_done);
        $display("Checks failed");
        $finish;
      end
    end
  end

endmodule

// File: vlog.f
+incdir+include
src/lsu_pkg.sv
src/lsu_ctrl.sv
src/lsu_agu.sv
src/lsu_dcache.sv
src/lsu_load_align.sv
src/lsu_pipe.sv
dv/tb_lsu_pipe.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log for the pass line

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal -f vlog.f --top-module tb_lsu_pipe -o sim_lsu \
  > build.log 2>&1 &&
  ./obj_dir/sim_lsu | tee sim.log ||
  echo "Build or run failed, see build.log"

grep -qx "All checks passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
